// File: common/harness_pkg.sv
/*
 * Shared sizes, address map, boot ROM image, DMI register map
 * and the bus and DMI types of the SoC test harness
 */
package harness_pkg;

  // ----------------------------------------------------------------------
  // System bus and memories
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth    = 64;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned BeWidth      = 8;
  localparam int unsigned ByteOffset   = $clog2(BeWidth);
  localparam int unsigned SramWords    = 256;
  localparam int unsigned SramIdxWidth = $clog2(SramWords);
  localparam int unsigned RomWords     = 8;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);

  localparam logic [AddrWidth-1:0] RomBase    = 64'h0000_0000_0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = RomWords * BeWidth;
  localparam logic [AddrWidth-1:0] GpioBase   = 64'h0000_0000_4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 64'h0000_0000_0000_1000;
  localparam logic [AddrWidth-1:0] DramBase   = 64'h0000_0000_8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = SramWords * BeWidth;

  // Boot code, two instructions per word
  localparam logic [DataWidth-1:0] RomImage [RomWords] = '{
    64'h0202_8593_0000_0297,
    64'h0182_b283_f140_2573,
    64'h0000_0000_0002_8067,
    64'h0000_0000_8000_0000,
    64'h0010_0073_0ff0_000f,
    64'h0000_0013_0000_0013,
    64'hffdf_f06f_1050_0073,
    64'h0000_0000_0000_0000
  };

  // ----------------------------------------------------------------------
  // Debug
  // ----------------------------------------------------------------------
  localparam int unsigned DmiDelCycles = 500;
  localparam int unsigned DmiDelWidth  = $clog2(DmiDelCycles + 1);
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  localparam logic [DmiAddrWidth-1:0] DmControlAddr = 7'h10;
  localparam logic [DmiAddrWidth-1:0] Data0Addr     = 7'h04;

  // Control register fields
  localparam int unsigned HaltReqBit  = 31;
  localparam int unsigned NdmResetBit = 1;
  localparam int unsigned DmActiveBit = 0;

  typedef enum logic [1:0] {
    NOP   = 2'h0,
    READ  = 2'h1,
    WRITE = 2'h2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DMI_OK     = 2'h0,
    DMI_FAILED = 2'h2
  } dmi_resp_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    dmi_resp_e               resp;
    logic [DmiDataWidth-1:0] data;
  } dmi_rsp_t;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {ROM, DRAM, GPIO, NONE} region_e;

  typedef enum logic {IDLE, RESP} dmi_state_e;

endpackage

// File: hw/rst_gen.sv
/* System reset generator, asynchronous assert and two-flop synchronous release */
`timescale 1ns/1ps

module rst_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_n;
  logic [1:0] sync_q;

  // Power-on or non-debug reset
  assign rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

// File: hw/debug/dmi_ctrl.sv
/*
 * DMI controller: source select between JTAG and DTM ports,
 * request acceptance and response hold until taken
 */
`timescale 1ns/1ps

module dmi_ctrl import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     jtag_sel_i,
  input  dmi_req_t jtag_req_i,
  input  logic     jtag_req_valid_i,
  input  logic     jtag_rsp_ready_i,
  input  dmi_req_t dtm_req_i,
  input  logic     dtm_req_valid_i,
  input  logic     dtm_rsp_ready_i,
  output logic     access_o,
  output dmi_req_t access_req_o,
  input  dmi_rsp_t access_rsp_i,
  output logic     dmi_req_ready_o,
  output dmi_rsp_t dmi_rsp_o,
  output logic     jtag_rsp_valid_o,
  output logic     dtm_rsp_valid_o
);

  dmi_state_e state_d;
  dmi_state_e state_q;
  logic       src_jtag_q;
  logic       req_valid;
  logic       rsp_ready;
  logic       rsp_valid;
  dmi_rsp_t   rsp_q;

  // Source mux
  assign req_valid    = jtag_sel_i ? jtag_req_valid_i : dtm_req_valid_i;
  assign access_req_o = jtag_sel_i ? jtag_req_i : dtm_req_i;
  // Ready comes from the source that issued the transfer
  assign rsp_ready    = src_jtag_q ? jtag_rsp_ready_i : dtm_rsp_ready_i;

  assign dmi_req_ready_o = (state_q == IDLE);
  assign access_o        = dmi_req_ready_o & req_valid;
  assign rsp_valid       = (state_q == RESP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (access_o) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (rsp_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      src_jtag_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (access_o) begin
        src_jtag_q <= jtag_sel_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_o) begin
      rsp_q <= access_rsp_i;
    end
  end

  assign dmi_rsp_o        = rsp_q;
  assign jtag_rsp_valid_o = rsp_valid & src_jtag_q;
  assign dtm_rsp_valid_o  = rsp_valid & ~src_jtag_q;

endmodule

// File: hw/debug/dm_regs.sv
/* Debug registers: control and Data0 with DMI read/write decode */
`timescale 1ns/1ps

module dm_regs import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     access_i,
  input  dmi_req_t req_i,
  output dmi_rsp_t rsp_o,
  output logic     haltreq_o,
  output logic     ndmreset_o
);

  logic [DmiDataWidth-1:0] dmcontrol_q;
  logic [DmiDataWidth-1:0] data0_q;
  logic                    ctrl_hit;
  logic                    data0_hit;

  assign ctrl_hit  = (req_i.addr == DmControlAddr);
  assign data0_hit = (req_i.addr == Data0Addr);

  always_comb begin
    rsp_o.resp = DMI_OK;
    rsp_o.data = '0;
    if (req_i.op != NOP) begin
      if (!ctrl_hit && !data0_hit) begin
        rsp_o.resp = DMI_FAILED;
      end else if (req_i.op == READ) begin
        rsp_o.data = ctrl_hit ? dmcontrol_q : data0_q;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      data0_q     <= '0;
    end else if (access_i && req_i.op == WRITE) begin
      if (ctrl_hit) begin
        dmcontrol_q <= req_i.data;
      end
      if (data0_hit) begin
        data0_q <= req_i.data;
      end
    end
  end

  // Control bits act only while the module is active
  assign haltreq_o  = dmcontrol_q[HaltReqBit] & dmcontrol_q[DmActiveBit];
  assign ndmreset_o = dmcontrol_q[NdmResetBit] & dmcontrol_q[DmActiveBit];

endmodule

// File: hw/debug/debug_delay.sv
/* Power-on delay counter that holds back the halt request */
`timescale 1ns/1ps

module debug_delay import harness_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_en_i,
  input  logic haltreq_i,
  output logic debug_req_o
);

  logic [DmiDelWidth-1:0] cnt_q;
  logic                   cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // Counts down once after power-on reset, then stays at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DmiDelWidth'(DmiDelCycles);
    end else if (!cnt_zero) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = cnt_zero & debug_en_i & haltreq_i;

endmodule

// File: hw/mem/sram.sv
/* Word-addressed SRAM with byte enables and registered read */
`timescale 1ns/1ps

module sram import harness_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    we_i,
  input  logic                    re_i,
  input  logic [SramIdxWidth-1:0] idx_i,
  input  logic [BeWidth-1:0]      be_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] mem_q [SramWords];
  logic [DataWidth-1:0] rdata_q;

  // Byte lanes written under their enables
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (re_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hw/mem/bus_router.sv
/* System bus router: address decode, boot ROM, SRAM access and error response */
`timescale 1ns/1ps

module bus_router import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  logic [AddrWidth-1:0] addr;
  region_e              region_d;
  region_e              region_q;
  logic                 rvalid_q;
  logic                 we_q;
  logic [DataWidth-1:0] rom_word_q;
  logic [DataWidth-1:0] sram_rdata;
  logic                 sram_we;
  logic                 sram_re;

  assign addr = bus_req_i.addr;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  always_comb begin
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      region_d = ROM;
    end else if (addr >= DramBase && addr < DramBase + DramLength) begin
      region_d = DRAM;
    end else if (addr >= GpioBase && addr < GpioBase + GpioLength) begin
      region_d = GPIO;
    end else begin
      region_d = NONE;
    end
  end

  assign sram_we = bus_req_i.req & bus_req_i.we & (region_d == DRAM);
  assign sram_re = bus_req_i.req & ~bus_req_i.we & (region_d == DRAM);

  sram u_sram (
    .clk_i   ( clk_i                               ),
    .rst_ni  ( rst_ni                              ),
    .we_i    ( sram_we                             ),
    .re_i    ( sram_re                             ),
    .idx_i   ( addr[ByteOffset +: SramIdxWidth]    ),
    .be_i    ( bus_req_i.be                        ),
    .wdata_i ( bus_req_i.wdata                     ),
    .rdata_o ( sram_rdata                          )
  );

  // ----------------------------------------------------------------------
  // Response cycle
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      region_q <= NONE;
      we_q     <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        region_q <= region_d;
        we_q     <= bus_req_i.we;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rom_word_q <= RomImage[addr[ByteOffset +: RomIdxWidth]];
    end
  end

  always_comb begin
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.err    = 1'b0;
    bus_rsp_o.rdata  = '0;
    if (rvalid_q) begin
      case (region_q)
        DRAM: begin
          if (!we_q) begin
            bus_rsp_o.rdata = sram_rdata;
          end
        end
        // ROM is read-only
        ROM: begin
          if (we_q) begin
            bus_rsp_o.err = 1'b1;
          end else begin
            bus_rsp_o.rdata = rom_word_q;
          end
        end
        default: bus_rsp_o.err = 1'b1;
      endcase
    end
  end

endmodule

// File: hw/soc_harness.sv
/* SoC test harness top: debug path, reset generation and system bus */
`timescale 1ns/1ps

module soc_harness import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     jtag_sel_i,
  input  logic     debug_en_i,
  input  dmi_req_t jtag_req_i,
  input  logic     jtag_req_valid_i,
  input  logic     jtag_rsp_ready_i,
  input  dmi_req_t dtm_req_i,
  input  logic     dtm_req_valid_i,
  input  logic     dtm_rsp_ready_i,
  output logic     dmi_req_ready_o,
  output dmi_rsp_t dmi_rsp_o,
  output logic     jtag_rsp_valid_o,
  output logic     dtm_rsp_valid_o,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     debug_req_o,
  output logic     sys_rst_no
);

  logic     dm_access;
  dmi_req_t dm_req;
  dmi_rsp_t dm_rsp;
  logic     haltreq;
  logic     ndmreset;

  // ----------------------------------------------------------------------
  // Debug path
  // ----------------------------------------------------------------------
  dmi_ctrl u_dmi_ctrl (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .jtag_sel_i       ( jtag_sel_i       ),
    .jtag_req_i       ( jtag_req_i       ),
    .jtag_req_valid_i ( jtag_req_valid_i ),
    .jtag_rsp_ready_i ( jtag_rsp_ready_i ),
    .dtm_req_i        ( dtm_req_i        ),
    .dtm_req_valid_i  ( dtm_req_valid_i  ),
    .dtm_rsp_ready_i  ( dtm_rsp_ready_i  ),
    .access_o         ( dm_access        ),
    .access_req_o     ( dm_req           ),
    .access_rsp_i     ( dm_rsp           ),
    .dmi_req_ready_o  ( dmi_req_ready_o  ),
    .dmi_rsp_o        ( dmi_rsp_o        ),
    .jtag_rsp_valid_o ( jtag_rsp_valid_o ),
    .dtm_rsp_valid_o  ( dtm_rsp_valid_o  )
  );

  dm_regs u_dm_regs (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .access_i   ( dm_access ),
    .req_i      ( dm_req    ),
    .rsp_o      ( dm_rsp    ),
    .haltreq_o  ( haltreq   ),
    .ndmreset_o ( ndmreset  )
  );

  debug_delay u_debug_delay (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_en_i  ( debug_en_i  ),
    .haltreq_i   ( haltreq     ),
    .debug_req_o ( debug_req_o )
  );

  // System side runs on the generated reset
  rst_gen u_rst_gen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset   ),
    .sys_rst_no ( sys_rst_no )
  );

  bus_router u_bus_router (
    .clk_i     ( clk_i      ),
    .rst_ni    ( sys_rst_no ),
    .bus_req_i ( bus_req_i  ),
    .bus_rsp_o ( bus_rsp_o  )
  );

endmodule

// File: sim/soc_harness_asserts.sv
/* Concurrent checks on bus response timing, DMI responses and halt gating */
`timescale 1ns/1ps

module soc_harness_asserts import harness_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     sys_rst_ni,
  input bus_req_t bus_req_i,
  input bus_rsp_t bus_rsp_i,
  input logic     jtag_rsp_valid_i,
  input logic     dtm_rsp_valid_i,
  input logic     jtag_rsp_ready_i,
  input logic     dtm_rsp_ready_i,
  input dmi_rsp_t dmi_rsp_i,
  input logic     debug_req_i
);

  int unsigned            fail_cnt = 0;
  logic [DmiDelWidth-1:0] since_rst_q;

  // Edges since power-on reset, saturating at the delay length
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= '0;
    end else if (since_rst_q < DmiDelWidth'(DmiDelCycles)) begin
      since_rst_q <= since_rst_q + DmiDelWidth'(1);
    end
  end

  // ----------------------------------------------------------------------
  // Bus response timing
  // ----------------------------------------------------------------------
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    bus_req_i.req |=> bus_rsp_i.rvalid)
    else begin
      $error("rvalid missing one cycle after a request");
      fail_cnt++;
    end

  no_rvalid_without_req: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    !bus_req_i.req |=> !bus_rsp_i.rvalid)
    else begin
      $error("rvalid high without a request in the previous cycle");
      fail_cnt++;
    end

  // ----------------------------------------------------------------------
  // DMI response and halt gating
  // ----------------------------------------------------------------------
  rsp_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(jtag_rsp_valid_i && dtm_rsp_valid_i))
    else begin
      $error("both DMI response valids high");
      fail_cnt++;
    end

  jtag_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (jtag_rsp_valid_i && !jtag_rsp_ready_i) |=> (jtag_rsp_valid_i && $stable(dmi_rsp_i)))
    else begin
      $error("JTAG response changed before it was taken");
      fail_cnt++;
    end

  dtm_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dtm_rsp_valid_i && !dtm_rsp_ready_i) |=> (dtm_rsp_valid_i && $stable(dmi_rsp_i)))
    else begin
      $error("DTM response changed before it was taken");
      fail_cnt++;
    end

  halt_held_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q < DmiDelWidth'(DmiDelCycles)) |-> !debug_req_i)
    else begin
      $error("debug request raised inside the power-on delay");
      fail_cnt++;
    end

endmodule

// File: sim/tb_soc_harness.sv
/*
 * Testbench for the SoC harness with DMI and bus stimulus, a byte-level
 * memory model, watchdog and result summary
 */
`timescale 1ns/1ps

module tb_soc_harness import harness_pkg::*; ();

  localparam int unsigned DramTestWords = 16;
  // Delay window plus two-cycle bus accesses and DMI transfers, doubled below
  localparam int unsigned TestCycles    = DmiDelCycles + 2 * (3 * DramTestWords + RomWords + 8)
                                          + 12 * 8;
  localparam int unsigned TimeoutCycles = 2 * TestCycles;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     jtag_sel_i;
  logic     debug_en_i;
  dmi_req_t jtag_req_i;
  logic     jtag_req_valid_i;
  logic     jtag_rsp_ready_i;
  dmi_req_t dtm_req_i;
  logic     dtm_req_valid_i;
  logic     dtm_rsp_ready_i;
  logic     dmi_req_ready_o;
  dmi_rsp_t dmi_rsp_o;
  logic     jtag_rsp_valid_o;
  logic     dtm_rsp_valid_o;
  bus_req_t bus_req_i;
  bus_rsp_t bus_rsp_o;
  logic     debug_req_o;
  logic     sys_rst_no;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cyc    = 0;
  logic [31:0] rand_state = 32'h652c;
  logic [7:0]  mem_model [SramWords*BeWidth];

  always #20 clk_i = ~clk_i;

  // Rising edges since power-on reset was released
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  soc_harness u_dut (.*);

  bind soc_harness soc_harness_asserts u_asserts (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .sys_rst_ni       ( sys_rst_no       ),
    .bus_req_i        ( bus_req_i        ),
    .bus_rsp_i        ( bus_rsp_o        ),
    .jtag_rsp_valid_i ( jtag_rsp_valid_o ),
    .dtm_rsp_valid_i  ( dtm_rsp_valid_o  ),
    .jtag_rsp_ready_i ( jtag_rsp_ready_i ),
    .dtm_rsp_ready_i  ( dtm_rsp_ready_i  ),
    .dmi_rsp_i        ( dmi_rsp_o        ),
    .debug_req_i      ( debug_req_o      )
  );

  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic logic [63:0] dram_addr(input int unsigned idx);
    return DramBase + 64'(idx * BeWidth);
  endfunction

  function automatic logic [63:0] model_word(input int unsigned idx);
    logic [63:0] word;
    for (int b = 0; b < BeWidth; b++) begin
      word[b*8 +: 8] = mem_model[idx*BeWidth + b];
    end
    return word;
  endfunction

  task automatic model_write(input int unsigned idx, input logic [7:0] be,
                             input logic [63:0] data);
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        mem_model[idx*BeWidth + b] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure: %s", what);
  endtask

  // ----------------------------------------------------------------------
  // Bus and DMI access
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [63:0] addr, input logic [7:0] be,
                            input logic [63:0] wdata, output bus_rsp_t rsp);
    bus_req_t req;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    @(posedge clk_i);
    bus_req_i <= req;
    @(posedge clk_i);
    bus_req_i.req <= 1'b0;
    @(negedge clk_i);
    rsp = bus_rsp_o;
    check_value("bus rvalid", 64'h1, rsp.rvalid);
  endtask

  task automatic check_dram(input int unsigned idx, input string name);
    bus_rsp_t rsp;
    bus_access(1'b0, dram_addr(idx), 8'hff, 64'h0, rsp);
    check_value(name, model_word(idx), rsp.rdata);
    check_value({name, " err"}, 64'h0, rsp.err);
  endtask

  // Returns just after the edge that accepted the request
  task automatic dmi_send(input logic jtag, input logic [6:0] addr, input dmi_op_e op,
                          input logic [31:0] data);
    dmi_req_t    req;
    int unsigned waited;
    req.addr = addr;
    req.op   = op;
    req.data = data;
    waited   = 0;
    @(posedge clk_i);
    jtag_sel_i <= jtag;
    if (jtag) begin
      jtag_req_i       <= req;
      jtag_req_valid_i <= 1'b1;
    end else begin
      dtm_req_i       <= req;
      dtm_req_valid_i <= 1'b1;
    end
    do begin
      @(negedge clk_i);
      waited++;
    end while (!dmi_req_ready_o && waited < 20);
    if (!dmi_req_ready_o) begin
      report_failure("DMI request was never accepted");
    end
    @(posedge clk_i);
    jtag_req_valid_i <= 1'b0;
    dtm_req_valid_i  <= 1'b0;
  endtask

  task automatic dmi_take(input logic jtag, output dmi_rsp_t rsp);
    int unsigned waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!(jtag ? jtag_rsp_valid_o : dtm_rsp_valid_o) && waited < 20);
    if (!(jtag ? jtag_rsp_valid_o : dtm_rsp_valid_o)) begin
      report_failure("DMI response valid never rose on the selected source");
    end
    check_value("dmi unselected valid", 64'h0, jtag ? dtm_rsp_valid_o : jtag_rsp_valid_o);
    // One transfer outstanding at a time
    check_value("dmi ready while busy", 64'h0, dmi_req_ready_o);
    rsp = dmi_rsp_o;
    // Response is held while ready stays low
    repeat (2) @(posedge clk_i);
    jtag_rsp_ready_i <= jtag;
    dtm_rsp_ready_i  <= ~jtag;
    @(posedge clk_i);
    jtag_rsp_ready_i <= 1'b0;
    dtm_rsp_ready_i  <= 1'b0;
  endtask

  task automatic dmi_xfer(input logic jtag, input logic [6:0] addr, input dmi_op_e op,
                          input logic [31:0] data, output dmi_rsp_t rsp);
    dmi_send(jtag, addr, op, data);
    dmi_take(jtag, rsp);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  initial begin
    dmi_rsp_t    drsp;
    bus_rsp_t    brsp;
    logic [31:0] d0;
    logic [63:0] wdata;
    logic [7:0]  be;
    int unsigned idx;
    int unsigned fails;
    rst_ni           = 1'b0;
    jtag_sel_i       = 1'b0;
    debug_en_i       = 1'b1;
    jtag_req_i       = '0;
    jtag_req_valid_i = 1'b0;
    jtag_rsp_ready_i = 1'b0;
    dtm_req_i        = '0;
    dtm_req_valid_i  = 1'b0;
    dtm_rsp_ready_i  = 1'b0;
    bus_req_i        = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Halt request set early and held back for the delay window
    dmi_xfer(1'b1, DmControlAddr, WRITE, 32'h8000_0001, drsp);
    while (cyc < DmiDelCycles + 4) begin
      @(negedge clk_i);
      check_value("halt gating", 64'(cyc >= DmiDelCycles), 64'(debug_req_o));
    end
    @(posedge clk_i);
    debug_en_i <= 1'b0;
    @(negedge clk_i);
    check_value("halt with debug disabled", 64'h0, debug_req_o);
    @(posedge clk_i);
    debug_en_i <= 1'b1;
    @(negedge clk_i);
    check_value("halt with debug enabled", 64'h1, debug_req_o);

    // Data0 through both sources
    d0 = next_rand();
    dmi_xfer(1'b0, Data0Addr, WRITE, d0, drsp);
    check_value("dtm data0 write resp", DMI_OK, drsp.resp);
    dmi_xfer(1'b1, Data0Addr, READ, 32'h0, drsp);
    check_value("jtag data0 read", d0, drsp.data);
    dmi_xfer(1'b0, 7'h7f, READ, 32'h0, drsp);
    check_value("unknown dmi address resp", DMI_FAILED, drsp.resp);

    for (int i = 0; i < DramTestWords; i++) begin
      idx   = (i * 37 + 5) % SramWords;
      wdata = {next_rand(), next_rand()};
      bus_access(1'b1, dram_addr(idx), 8'hff, wdata, brsp);
      model_write(idx, 8'hff, wdata);
      wdata = {next_rand(), next_rand()};
      be    = 8'(next_rand());
      bus_access(1'b1, dram_addr(idx), be, wdata, brsp);
      model_write(idx, be, wdata);
      check_value("dram write err", 64'h0, brsp.err);
    end
    for (int i = 0; i < DramTestWords; i++) begin
      check_dram((i * 37 + 5) % SramWords, "dram read");
    end

    for (int i = 0; i < RomWords; i++) begin
      bus_access(1'b0, RomBase + 64'(i * BeWidth), 8'hff, 64'h0, brsp);
      check_value("rom read", RomImage[i], brsp.rdata);
      check_value("rom read err", 64'h0, brsp.err);
    end
    bus_access(1'b1, RomBase, 8'hff, 64'h0, brsp);
    check_value("rom write err", 64'h1, brsp.err);

    bus_access(1'b0, GpioBase + 64'h10, 8'hff, 64'h0, brsp);
    check_value("gpio err", 64'h1, brsp.err);
    check_value("gpio rdata", 64'h0, brsp.rdata);
    bus_access(1'b0, 64'h0000_0000_2000_0000, 8'hff, 64'h0, brsp);
    check_value("unmapped err", 64'h1, brsp.err);
    check_value("unmapped rdata", 64'h0, brsp.rdata);

    // Non-debug reset and its release two edges after the bit clears
    dmi_send(1'b0, DmControlAddr, WRITE, 32'h0000_0003);
    @(negedge clk_i);
    check_value("sys reset asserted", 64'h0, sys_rst_no);
    dmi_take(1'b0, drsp);
    dmi_send(1'b0, DmControlAddr, WRITE, 32'h0000_0001);
    for (int k = 0; k < 3; k++) begin
      @(negedge clk_i);
      check_value("sys reset release", 64'(k == 2), sys_rst_no);
    end
    dmi_take(1'b0, drsp);
    for (int i = 0; i < 4; i++) begin
      check_dram((i * 37 + 5) % SramWords, "dram after sys reset");
    end

    repeat (2) @(posedge clk_i);
    fails = errors + u_dut.u_asserts.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_asserts.fail_cnt);
    if (fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog expired: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: all.f
common/harness_pkg.sv
hw/rst_gen.sv
hw/debug/dmi_ctrl.sv
hw/debug/dm_regs.sv
hw/debug/debug_delay.sv
hw/mem/sram.sv
hw/mem/bus_router.sv
hw/soc_harness.sv
sim/soc_harness_asserts.sv
sim/tb_soc_harness.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the SoC harness testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_harness -f all.f -o tb_soc_harness

# Assertion errors must not stop the run before the summary line
./obj_dir/tb_soc_harness +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
